//--- fpu_pkg.sv
/*
 * fpu shared definitions: single-precision field widths, special-case
 * flags and the symbol set shown on the seven-segment digits.
 */
`default_nettype none

package fpu_pkg;

	localparam int exp_width = 8; // biased exponent bits.
	localparam int man_width = 23; // stored mantissa bits, hidden one excluded.
	localparam int exp_bias  = 127;

	// flags raised by the multiplier alongside its result.
	typedef struct packed {
		logic nan;
		logic inf;
		logic overflow;
		logic underflow;
	} special_t;

	// display symbols, hex digits first so a nibble maps straight onto them.
	typedef enum logic [4:0] {
		glyph_0     = 5'd0,
		glyph_1     = 5'd1,
		glyph_2     = 5'd2,
		glyph_3     = 5'd3,
		glyph_4     = 5'd4,
		glyph_5     = 5'd5,
		glyph_6     = 5'd6,
		glyph_7     = 5'd7,
		glyph_8     = 5'd8,
		glyph_9     = 5'd9,
		glyph_a     = 5'd10, // also the operand A tag.
		glyph_b     = 5'd11, // also the operand b tag.
		glyph_c     = 5'd12,
		glyph_d     = 5'd13,
		glyph_e     = 5'd14,
		glyph_f     = 5'd15,
		glyph_r     = 5'd16,
		glyph_n     = 5'd17,
		glyph_i     = 5'd18,
		glyph_o     = 5'd19,
		glyph_u     = 5'd20,
		glyph_blank = 5'd21
	} glyph_t;

endpackage

`default_nettype wire

//--- peripheral_pulse.sv
/*
 * enter button conditioner: synchronizes the raw level and emits a
 * single-cycle pulse for each rising edge.
 */
`timescale 1ns/1ns
`default_nettype none

module peripheral_pulse #(
	parameter int SYNC_STAGES = 2
) (
	input  logic clk,
	input  logic reset,
	input  logic enter,
	output logic pulse
);

	logic [SYNC_STAGES-1:0] sync_q; // metastability chain.
	logic                   edge_q; // last synchronized level.

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			sync_q <= '0;
			edge_q <= 1'b0;
		end else begin
			sync_q <= {sync_q[SYNC_STAGES-2:0], enter};
			edge_q <= sync_q[SYNC_STAGES-1];
		end
	end

	// high only in the cycle where the clean level has risen.
	assign pulse = sync_q[SYNC_STAGES-1] & ~edge_q;

endmodule

`default_nettype wire

//--- peripheral_getoperands.sv
/*
 * operand register block: each accepted pulse in load mode stores the
 * switch byte into operand A (index 0-3) or operand B (index 4-7).
 */
`timescale 1ns/1ns
`default_nettype none

module peripheral_getoperands (
	input  logic        clk,
	input  logic        reset,
	input  logic [7:0]  inputdata,
	input  logic        loaddata,
	input  logic        pulse,
	input  logic [2:0]  count,
	output logic [31:0] data_a,
	output logic [31:0] data_b
);

	logic write_en;

	assign write_en = pulse & loaddata; // result mode never writes.

	// count is the pre-increment index on the same edge as the counter.
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			data_a <= '0;
			data_b <= '0;
		end else if (write_en) begin
			if (!count[2]) begin
				data_a[8*count[1:0] +: 8] <= inputdata; // byte 0 is the low byte.
			end else begin
				data_b[8*count[1:0] +: 8] <= inputdata;
			end
		end
	end

endmodule

`default_nettype wire

//--- peripheral_deco7seg.sv
/*
 * seven-segment decoder: one display symbol to active-low segments,
 * bit order g down to a.
 */
`timescale 1ns/1ns
`default_nettype none

module peripheral_deco7seg (
	input  fpu_pkg::glyph_t glyph,
	output logic [6:0]      segments
);

	logic [6:0] lit; // active-high pattern, gfedcba.

	always_comb begin
		case (glyph)
			fpu_pkg::glyph_0: lit = 7'h3f;
			fpu_pkg::glyph_1: lit = 7'h06;
			fpu_pkg::glyph_2: lit = 7'h5b;
			fpu_pkg::glyph_3: lit = 7'h4f;
			fpu_pkg::glyph_4: lit = 7'h66;
			fpu_pkg::glyph_5: lit = 7'h6d;
			fpu_pkg::glyph_6: lit = 7'h7d;
			fpu_pkg::glyph_7: lit = 7'h07;
			fpu_pkg::glyph_8: lit = 7'h7f;
			fpu_pkg::glyph_9: lit = 7'h6f;
			fpu_pkg::glyph_a: lit = 7'h77;
			fpu_pkg::glyph_b: lit = 7'h7c; // lower-case b.
			fpu_pkg::glyph_c: lit = 7'h39;
			fpu_pkg::glyph_d: lit = 7'h5e; // lower-case d.
			fpu_pkg::glyph_e: lit = 7'h79;
			fpu_pkg::glyph_f: lit = 7'h71;
			fpu_pkg::glyph_r: lit = 7'h50; // segments e and g.
			fpu_pkg::glyph_n: lit = 7'h54;
			// left-hand bar, kept apart from the digit 1.
			fpu_pkg::glyph_i: lit = 7'h30;
			fpu_pkg::glyph_o: lit = 7'h5c;
			fpu_pkg::glyph_u: lit = 7'h3e;
			fpu_pkg::glyph_blank: lit = 7'h00;
			default: lit = 7'h00;
		endcase
	end

	assign segments = ~lit; // common-anode digits.

endmodule

`default_nettype wire

//--- peripherals.sv
/*
 * board peripherals: byte counter and ready flag, operand loading and
 * the four-digit display of operands, result and special cases.
 */
`timescale 1ns/1ns
`default_nettype none

module peripherals #(
	parameter int SYNC_STAGES = 2
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              enter,
	input  logic [7:0]        inputdata,
	input  logic              loaddata,
	input  fpu_pkg::special_t special,
	input  logic [31:0]       data_r,
	output logic [31:0]       data_a,
	output logic [31:0]       data_b,
	output logic              inputdata_ready,
	output logic [6:0]        disp3,
	output logic [6:0]        disp2,
	output logic [6:0]        disp1,
	output logic [6:0]        disp0
);

	logic            pulse;
	logic [2:0]      count;
	logic [31:0]     shown_word; // operand or result under the index.
	logic [7:0]      shown_byte;
	fpu_pkg::glyph_t glyph3, glyph2, glyph1, glyph0;

	peripheral_pulse #(
		.SYNC_STAGES(SYNC_STAGES)
	) u_pulse (
		.clk  (clk),
		.reset(reset),
		.enter(enter),
		.pulse(pulse)
	);

	// index advances in both modes; ready marks a completed pass of eight.
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			count           <= 3'd0;
			inputdata_ready <= 1'b0;
		end else if (pulse) begin
			if (count < 3'd7) begin
				count           <= count + 3'd1;
				inputdata_ready <= 1'b0;
			end else begin
				count           <= 3'd0;
				inputdata_ready <= 1'b1;
			end
		end
	end

	peripheral_getoperands u_getoperands (
		.clk      (clk),
		.reset    (reset),
		.inputdata(inputdata),
		.loaddata (loaddata),
		.pulse    (pulse),
		.count    (count),
		.data_a   (data_a),
		.data_b   (data_b)
	);

	always_comb begin
		if (loaddata) begin
			shown_word = count[2] ? data_b : data_a;
		end else begin
			shown_word = data_r;
		end
		shown_byte = shown_word[8*count[1:0] +: 8];

		// default layout: tag, index, high nibble, low nibble.
		glyph2 = fpu_pkg::glyph_t'({3'b000, count[1:0]});
		glyph1 = fpu_pkg::glyph_t'({1'b0, shown_byte[7:4]});
		glyph0 = fpu_pkg::glyph_t'({1'b0, shown_byte[3:0]});
		if (loaddata) begin
			glyph3 = count[2] ? fpu_pkg::glyph_b : fpu_pkg::glyph_a;
		end else begin
			glyph3 = fpu_pkg::glyph_r;
		end

		// result mode messages, most severe first.
		if (!loaddata) begin
			if (special.nan) begin
				glyph3 = fpu_pkg::glyph_blank;
				glyph2 = fpu_pkg::glyph_n;
				glyph1 = fpu_pkg::glyph_a;
				glyph0 = fpu_pkg::glyph_n;
			end else if (special.inf) begin
				glyph3 = fpu_pkg::glyph_blank;
				glyph2 = fpu_pkg::glyph_i;
				glyph1 = fpu_pkg::glyph_n;
				glyph0 = fpu_pkg::glyph_f;
			end else if (special.overflow) begin
				glyph3 = fpu_pkg::glyph_o;
				glyph2 = fpu_pkg::glyph_u;
				glyph1 = fpu_pkg::glyph_e;
				glyph0 = fpu_pkg::glyph_r;
			end else if (special.underflow) begin
				glyph3 = fpu_pkg::glyph_u;
				glyph2 = fpu_pkg::glyph_n;
				glyph1 = fpu_pkg::glyph_d;
				glyph0 = fpu_pkg::glyph_r;
			end
		end
	end

	peripheral_deco7seg u_deco3 (.glyph(glyph3), .segments(disp3));
	peripheral_deco7seg u_deco2 (.glyph(glyph2), .segments(disp2));
	peripheral_deco7seg u_deco1 (.glyph(glyph1), .segments(disp1));
	peripheral_deco7seg u_deco0 (.glyph(glyph0), .segments(disp0));

endmodule

`default_nettype wire

//--- fp_multiplier.sv
/*
 * single-precision multiplier, truncating, with zero flushing and
 * special-case flags. Result and flags are registered.
 */
`timescale 1ns/1ns
`default_nettype none

module fp_multiplier (
	input  logic              clk,
	input  logic              reset,
	input  logic [31:0]       data_a,
	input  logic [31:0]       data_b,
	output logic [31:0]       data_r,
	output fpu_pkg::special_t special
);

	localparam int ew = fpu_pkg::exp_width;
	localparam int mw = fpu_pkg::man_width;

	logic                 sign_a, sign_b, sign_r;
	logic [ew-1:0]        exp_a, exp_b;
	logic [mw-1:0]        man_a, man_b;
	logic                 zero_a, zero_b, inf_a, inf_b, nan_a, nan_b;
	logic [2*mw+1:0]      product; // 24 x 24 significand product.
	logic                 norm; // product was in [2,4).
	logic [mw-1:0]        man_r;
	logic signed [ew+1:0] exp_sum; // wide enough for both extremes.
	logic [31:0]          result_d;
	fpu_pkg::special_t    special_d;

	// unpack the fields.
	assign sign_a = data_a[31];
	assign sign_b = data_b[31];
	assign exp_a  = data_a[30 -: ew];
	assign exp_b  = data_b[30 -: ew];
	assign man_a  = data_a[mw-1:0];
	assign man_b  = data_b[mw-1:0];

	assign zero_a = (exp_a == '0); // subnormals count as zero.
	assign zero_b = (exp_b == '0);
	assign inf_a  = (exp_a == '1) && (man_a == '0);
	assign inf_b  = (exp_b == '1) && (man_b == '0);
	assign nan_a  = (exp_a == '1) && (man_a != '0);
	assign nan_b  = (exp_b == '1) && (man_b != '0);

	assign sign_r  = sign_a ^ sign_b;
	assign product = {1'b1, man_a} * {1'b1, man_b};
	assign norm    = product[2*mw+1];

	// shift out the leading one and drop the rest.
	assign man_r = norm ? product[2*mw -: mw] : product[2*mw-1 -: mw];

	assign exp_sum = (ew+2)'(exp_a) + (ew+2)'(exp_b) + (ew+2)'(norm)
		- (ew+2)'(fpu_pkg::exp_bias);

	always_comb begin
		special_d = '0;
		if (nan_a || nan_b || (zero_a && inf_b) || (inf_a && zero_b)) begin
			result_d      = 32'h7fc0_0000; // canonical quiet NaN.
			special_d.nan = 1'b1;
		end else if (inf_a || inf_b) begin
			result_d      = {sign_r, {ew{1'b1}}, {mw{1'b0}}};
			special_d.inf = 1'b1;
		end else if (zero_a || zero_b) begin
			result_d = {sign_r, {(ew+mw){1'b0}}}; // exact zero, no flag.
		end else if (exp_sum >= 255) begin
			result_d           = {sign_r, {ew{1'b1}}, {mw{1'b0}}};
			special_d.overflow = 1'b1;
		end else if (exp_sum <= 0) begin
			result_d            = {sign_r, {(ew+mw){1'b0}}}; // flushed.
			special_d.underflow = 1'b1;
		end else begin
			result_d = {sign_r, exp_sum[ew-1:0], man_r};
		end
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			data_r  <= '0;
			special <= '0;
		end else begin
			data_r  <= result_d;
			special <= special_d;
		end
	end

endmodule

`default_nettype wire

//--- fpu_board_top.sv
/*
 * fpu board top level: switch and button peripherals driving the
 * floating-point multiplier, result shown on four digits.
 */
`timescale 1ns/1ns
`default_nettype none

module fpu_board_top #(
	parameter int SYNC_STAGES = 2
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       enter,
	input  logic [7:0] inputdata,
	input  logic       loaddata,
	output logic       inputdata_ready,
	output logic [6:0] disp3,
	output logic [6:0] disp2,
	output logic [6:0] disp1,
	output logic [6:0] disp0
);

	logic [31:0]       data_a, data_b, data_r;
	fpu_pkg::special_t special;

	peripherals #(
		.SYNC_STAGES(SYNC_STAGES)
	) u_peripherals (
		.clk            (clk),
		.reset          (reset),
		.enter          (enter),
		.inputdata      (inputdata),
		.loaddata       (loaddata),
		.special        (special),
		.data_r         (data_r),
		.data_a         (data_a),
		.data_b         (data_b),
		.inputdata_ready(inputdata_ready),
		.disp3          (disp3),
		.disp2          (disp2),
		.disp1          (disp1),
		.disp0          (disp0)
	);

	fp_multiplier u_fp_multiplier (
		.clk    (clk),
		.reset  (reset),
		.data_a (data_a),
		.data_b (data_b),
		.data_r (data_r),
		.special(special)
	);

endmodule

`default_nettype wire

//--- tb_fpu_board.sv
/*
 * fpu board testbench: loads operand bytes through the switches and button,
 * reads the seven-segment digits back as characters and checks them.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_fpu_board;

	typedef struct packed {
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		logic [31:0] msg; // four display characters, or "none" for a plain result.
	} vec_t;

	logic       clk;
	logic       reset;
	logic       enter;
	logic [7:0] inputdata;
	logic       loaddata;
	logic       inputdata_ready;
	logic [6:0] disp3, disp2, disp1, disp0;

	int     errors;
	integer seed;
	vec_t   vectors [0:8];

	fpu_board_top #(
		.SYNC_STAGES(2)
	) UUT (
		.clk            (clk),
		.reset          (reset),
		.enter          (enter),
		.inputdata      (inputdata),
		.loaddata       (loaddata),
		.inputdata_ready(inputdata_ready),
		.disp3          (disp3),
		.disp2          (disp2),
		.disp1          (disp1),
		.disp0          (disp0)
	);

	always #4 clk = ~clk;

	// one digit's segments back to the character it shows.
	function automatic logic [7:0] seg_char(input logic [6:0] seg);
		logic [6:0] lit;
		lit = ~seg;
		case (lit)
			7'h3f: return "0";
			7'h06: return "1";
			7'h5b: return "2";
			7'h4f: return "3";
			7'h66: return "4";
			7'h6d: return "5";
			7'h7d: return "6";
			7'h07: return "7";
			7'h7f: return "8";
			7'h6f: return "9";
			7'h77: return "A";
			7'h7c: return "b";
			7'h39: return "C";
			7'h5e: return "d";
			7'h79: return "E";
			7'h71: return "F";
			7'h50: return "r";
			7'h54: return "n";
			7'h30: return "I";
			7'h5c: return "o";
			7'h3e: return "U";
			7'h00: return " ";
			default: return "?";
		endcase
	endfunction

	function automatic logic [7:0] hex_char(input logic [3:0] n);
		case (n)
			4'ha: return "A";
			4'hb: return "b";
			4'hc: return "C";
			4'hd: return "d";
			4'he: return "E";
			4'hf: return "F";
			default: return 8'h30 + n;
		endcase
	endfunction

	// tag, index and the byte as two hex digits.
	function automatic logic [31:0] digits(input logic [7:0] tag, input logic [1:0] idx,
			input logic [7:0] bt);
		return {tag, hex_char({2'b00, idx}), hex_char(bt[7:4]), hex_char(bt[3:0])};
	endfunction

	// truncating single-precision product with flush to zero.
	function automatic logic [63:0] ref_mul(input logic [31:0] a, input logic [31:0] b);
		int          ea, eb, e;
		logic        s, za, zb, ia, ib, na, nb;
		logic [47:0] prod;
		logic [22:0] frac;
		ea = a[30:23];
		eb = b[30:23];
		s = a[31] ^ b[31];
		za = (ea == 0);
		zb = (eb == 0);
		ia = (ea == 255) && (a[22:0] == 0);
		ib = (eb == 255) && (b[22:0] == 0);
		na = (ea == 255) && (a[22:0] != 0);
		nb = (eb == 255) && (b[22:0] != 0);
		prod = {1'b1, a[22:0]} * {1'b1, b[22:0]};
		e = ea + eb - 127;
		if (prod[47]) begin
			frac = prod[46:24];
			e = e + 1;
		end else begin
			frac = prod[45:23];
		end
		if (na || nb || (za && ib) || (ia && zb))
			return {32'h7fc0_0000, " nAn"};
		if (ia || ib)
			return {s, 8'hff, 23'd0, " InF"};
		if (za || zb)
			return {s, 31'd0, "none"};
		if (e >= 255)
			return {s, 8'hff, 23'd0, "oUEr"};
		if (e <= 0)
			return {s, 31'd0, "Undr"};
		return {s, e[7:0], frac, "none"};
	endfunction

	task automatic check_display(input logic [31:0] expected);
		logic [31:0] shown;
		shown = {seg_char(disp3), seg_char(disp2), seg_char(disp1), seg_char(disp0)};
		if (shown !== expected) begin
			$display("[FAIL] %0t ns disp3..disp0 expected \"%s\" got \"%s\"",
				$time, expected, shown);
			errors++;
		end
	endtask

	task automatic wait_ready(input logic level);
		int cycles;
		cycles = 0;
		while (inputdata_ready !== level && cycles < 40) begin
			@(negedge clk);
			cycles++;
		end
		if (inputdata_ready !== level) begin
			$display("inputdata_ready did not reach %0b within 40 cycles at %0t ns",
				level, $time);
			errors++;
		end
	endtask

	task automatic press_enter;
		enter = 1'b1;
		repeat (6) @(negedge clk);
		enter = 1'b0;
		repeat (6) @(negedge clk);
	endtask

	task automatic load_operands(input logic [31:0] a, input logic [31:0] b);
		logic [63:0] both;
		both = {b, a};
		loaddata = 1'b1;
		for (int i = 0; i < 8; i++) begin
			inputdata = both[8*i +: 8];
			press_enter();
		end
		wait_ready(1'b1);
	endtask

	// second pass rewrites the same bytes, so each slot echoes what was stored.
	task automatic verify_operands(input logic [31:0] a, input logic [31:0] b);
		logic [63:0] both;
		both = {b, a};
		for (int i = 0; i < 8; i++) begin
			check_display(digits((i < 4) ? "A" : "b", i[1:0], both[8*i +: 8]));
			inputdata = both[8*i +: 8];
			press_enter();
			if (i == 0)
				wait_ready(1'b0);
		end
		wait_ready(1'b1);
	endtask

	task automatic show_result(input logic [31:0] r, input logic [31:0] msg);
		loaddata = 1'b0;
		inputdata = 8'h5a; // junk on the switches, must not reach the operands.
		@(negedge clk);
		for (int i = 0; i < 8; i++) begin
			if (msg == "none")
				check_display(digits("r", i[1:0], r[8*i[1:0] +: 8]));
			else
				check_display(msg);
			press_enter();
		end
	endtask

	task automatic run_vector(input vec_t v);
		load_operands(v.a, v.b);
		verify_operands(v.a, v.b);
		show_result(v.r, v.msg);
		loaddata = 1'b1;
		@(negedge clk);
		verify_operands(v.a, v.b); // operands survive result mode.
	endtask

	initial begin
		vec_t        v;
		logic [63:0] expect_rm;
		integer      rnd;
		clk = 1'b0;
		reset = 1'b1;
		enter = 1'b0;
		inputdata = 8'h00;
		loaddata = 1'b1;
		errors = 0;
		seed = 86;

		vectors[0] = '{32'h3fc0_0000, 32'h4000_0000, 32'h4040_0000, "none"};
		vectors[1] = '{32'h4040_0000, 32'h4040_0000, 32'h4110_0000, "none"};
		vectors[2] = '{32'hbf80_0000, 32'h40a0_0000, 32'hc0a0_0000, "none"};
		vectors[3] = '{32'h3faa_aaab, 32'h4040_0000, 32'h4080_0000, "none"}; // truncated.
		vectors[4] = '{32'h7f80_0001, 32'h3f80_0000, 32'h7fc0_0000, " nAn"};
		vectors[5] = '{32'h7f80_0000, 32'h4000_0000, 32'h7f80_0000, " InF"};
		vectors[6] = '{32'h7f00_0000, 32'h7f00_0000, 32'h7f80_0000, "oUEr"};
		vectors[7] = '{32'h0080_0000, 32'h0080_0000, 32'h0000_0000, "Undr"};
		vectors[8] = '{32'h0000_0000, 32'h7f80_0000, 32'h7fc0_0000, " nAn"};

		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		if (inputdata_ready !== 1'b0) begin
			$display("[FAIL] %0t ns inputdata_ready expected 0 got %b", $time, inputdata_ready);
			errors++;
		end
		check_display("A000");

		for (int i = 0; i < 9; i++)
			run_vector(vectors[i]);

		// random normal operands, exponents kept well inside range.
		for (int i = 0; i < 4; i++) begin
			rnd = $random(seed);
			v.a = rnd;
			rnd = $random(seed);
			v.a[30:23] = 8'd96 + rnd[5:0];
			rnd = $random(seed);
			v.b = rnd;
			rnd = $random(seed);
			v.b[30:23] = 8'd96 + rnd[5:0];
			expect_rm = ref_mul(v.a, v.b);
			v.r = expect_rm[63:32];
			v.msg = expect_rm[31:0];
			run_vector(v);
		end

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
fpu_pkg.sv
peripheral_pulse.sv
peripheral_getoperands.sv
peripheral_deco7seg.sv
peripherals.sv
fp_multiplier.sv
fpu_board_top.sv
tb_fpu_board.sv

//--- Bender.yml
package:
  name: fpu_board

sources:
  - fpu_pkg.sv
  - peripheral_pulse.sv
  - peripheral_getoperands.sv
  - peripheral_deco7seg.sv
  - peripherals.sv
  - fp_multiplier.sv
  - fpu_board_top.sv
  - target: test
    files:
      - tb_fpu_board.sv
